//--- run.sh
#!/bin/sh
# builds the memory slice testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mem_pipe_tb -f sim.f

out=$(./obj_dir/Vmem_pipe_tb || true)
echo "$out"
if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

//--- sim.f
verilog/mem_pkg.sv
verilog/mem_stage_if.sv
verilog/dmem_if.sv
verilog/ex_mem.sv
verilog/data_ram.sv
verilog/mem_access.sv
verilog/mem_pipe_top.sv
tb/mem_pipe_assert.sv
tb/mem_pipe_checker.sv
tb/mem_pipe_tb.sv

//--- tb/mem_pipe_assert.sv
////////////////////
// handshake and writeback rules, bound into mem_access
////////////////////
`default_nettype none

module mem_pipe_assert import mem_pkg::*; (
    input logic            clk,
    input logic            arst_n,
    input logic            req,
    input logic            ack,
    input logic            wb_valid,
    input logic [xlen-1:0] addr,
    input logic [xlen-1:0] wdata
);

    req_rise_ack_low: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(req) |-> !ack)
        else $error("req rose while ack was high");

    req_fields_stable: assert property (@(posedge clk) disable iff (!arst_n)
        req |=> !req || ($stable(addr) && $stable(wdata)))
        else $error("addr or wdata changed while req was high");

    ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(ack) |-> !$past(req))
        else $error("ack dropped before req");

    // a load or store writes back exactly once
    wb_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_valid && $past(req)) |=> !(wb_valid && $past(req)))
        else $error("wb_valid repeated for one load or store");

endmodule

bind mem_access mem_pipe_assert mem_pipe_assert_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (dmem.req),
    .ack      (dmem.ack),
    .wb_valid (wb_valid),
    .addr     (dmem.addr),
    .wdata    (dmem.wdata)
);

`default_nettype wire

//--- tb/mem_pipe_checker.sv
////////////////////
// exp_word is pushed when ex_valid and ex_ready meet at an edge
////////////////////
`default_nettype none

module mem_pipe_checker import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ex_valid,
    input  logic                   ex_ready,
    input  logic [inst_type_w-1:0] ex_inst_type,
    input  logic [38:0]            exp_word,     // {check data, rd_ena, rd_addr, rd_data}
    input  logic                   wb_valid,
    input  logic                   wb_rd_ena,
    input  logic [reg_addr_w-1:0]  wb_rd_addr,
    input  logic [xlen-1:0]        wb_rd_data,
    output int                     errors,
    output int                     pending
);

    logic [38:0] exp_q [$];
    logic [38:0] head;
    logic        mem_taken;

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_q.delete();
            mem_taken <= 1'b0;
            pending   <= 0;
        end else begin
            if (mem_taken && ex_ready) begin
                $display("ex_ready stayed high after a load or store was taken, at %0t", $time);
                errors++;
            end
            if (wb_valid) begin
                if (exp_q.size() == 0) begin
                    $display("wb_valid at %0t while no instruction was expected", $time);
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    compare_value("wb_rd_ena", 32'(head[37]), 32'(wb_rd_ena));
                    if (head[38]) begin      // stores carry no register result
                        compare_value("wb_rd_addr", 32'(head[36:32]), 32'(wb_rd_addr));
                        compare_value("wb_rd_data", head[31:0], wb_rd_data);
                    end
                end
            end
            if (ex_valid && ex_ready)
                exp_q.push_back(exp_word);
            mem_taken <= ex_valid && ex_ready &&
                         (ex_inst_type == inst_load || ex_inst_type == inst_store);
            pending   <= exp_q.size();
        end
    end

endmodule

`default_nettype wire

//--- tb/mem_pipe_tb.sv
////////////////////
// directed and random test, addresses stay in ram words 0 to 15
// those words are stored before any load reads them
////////////////////
`default_nettype none

module mem_pipe_tb import mem_pkg::*; ();

    localparam int n_directed = 34;
    localparam int n_random   = 400;
    localparam int max_cycles = 6 * (n_directed + n_random) + 50;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   ex_valid;
    logic                   ex_rd_ena;
    logic                   ex_ready;
    logic                   wb_valid;
    logic                   wb_rd_ena;
    logic [inst_type_w-1:0] ex_inst_type;
    logic [xlen-1:0]        ex_rd_data;
    logic [xlen-1:0]        ex_ls_addr;
    logic [xlen-1:0]        wb_rd_data;
    logic [reg_addr_w-1:0]  ex_rd_addr;
    logic [reg_addr_w-1:0]  wb_rd_addr;
    logic [2:0]             ex_ls_sel;
    logic [38:0]            exp_word;
    logic [15:0]            lfsr = 16'd35936;
    logic [xlen-1:0]        shadow [dmem_words];
    int                     chk_errors;
    int                     pending;
    int                     tb_errors;
    int                     cycles;

    always #5 clk = ~clk;

    mem_pipe_top mem_pipe_top_inst (.*);

    mem_pipe_checker mem_pipe_checker_inst (.*, .errors(chk_errors));

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // expected writeback as {check data, rd_ena, rd_addr, rd_data}
    function automatic logic [38:0] expect_result(input logic [inst_type_w-1:0] itype,
            input logic rd_ena, input logic [xlen-1:0] data,
            input logic [reg_addr_w-1:0] rd_addr, input logic [2:0] sel,
            input logic [xlen-1:0] addr);
        logic [xlen-1:0] word;
        logic [xlen-1:0] val;
        word = shadow[addr[9:2]] >> (8 * addr[1:0]);
        case (sel[1:0])
            size_byte: val = sel[2] ? {24'd0, word[7:0]} : {{24{word[7]}}, word[7:0]};
            size_half: val = sel[2] ? {16'd0, word[15:0]} : {{16{word[15]}}, word[15:0]};
            default:   val = word;
        endcase
        if (itype == inst_store)
            return {1'b0, 1'b0, rd_addr, data};
        if (itype == inst_load)
            return {1'b1, rd_ena, rd_addr, val};
        return {1'b1, rd_ena, rd_addr, data};
    endfunction

    function automatic void store_shadow(input logic [xlen-1:0] data, input logic [1:0] size,
                                         input logic [xlen-1:0] addr);
        logic [3:0]      strb;
        logic [xlen-1:0] lanes;
        case (size)
            size_byte: strb = 4'b0001 << addr[1:0];
            size_half: strb = 4'b0011 << addr[1:0];
            default:   strb = 4'b1111;
        endcase
        lanes = data << (8 * addr[1:0]);
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                shadow[addr[9:2]][8*i +: 8] = lanes[8*i +: 8];
        end
    endfunction

    task automatic issue(input logic valid, input logic [inst_type_w-1:0] itype,
                         input logic rd_ena, input logic [xlen-1:0] data,
                         input logic [reg_addr_w-1:0] rd_addr, input logic [2:0] sel,
                         input logic [xlen-1:0] addr);
        ex_valid     <= valid;
        ex_inst_type <= itype;
        ex_rd_ena    <= rd_ena;
        ex_rd_data   <= data;
        ex_rd_addr   <= rd_addr;
        ex_ls_sel    <= sel;
        ex_ls_addr   <= addr;
        exp_word     <= expect_result(itype, rd_ena, data, rd_addr, sel, addr);
        if (valid && itype == inst_store)
            store_shadow(data, sel[1:0], addr);
        do
            @(posedge clk);
        while (!ex_ready);                 // held until the register takes it
    endtask

    task automatic issue_random();
        logic [1:0]             kind;
        logic [1:0]             size;
        logic [inst_type_w-1:0] code;
        logic [xlen-1:0]        addr;
        logic [xlen-1:0]        data;
        logic [reg_addr_w-1:0]  rd_addr;
        logic                   rd_ena;
        logic [2:0]             sel;
        kind = 2'(take_bits(2));
        size = 2'(take_bits(2));
        if (size == 2'd3)
            size = size_word;
        addr = {22'(take_bits(22)), 4'b0000, 4'(take_bits(4)), 2'b00};
        if (size == size_byte)
            addr[1:0] = 2'(take_bits(2));
        else if (size == size_half)
            addr[1] = 1'(take_bits(1));
        sel     = {(kind == 2'd2 && size != size_word) ? 1'(take_bits(1)) : 1'b0, size};
        code    = (take_bits(2) == 0) ? 8'h40 : inst_alu;  // unknown code runs as alu
        rd_ena  = 1'(take_bits(1));
        rd_addr = 5'(take_bits(5));
        data    = take_bits(32);
        case (kind)
            2'd0:    issue(1'b0, '0, 1'b0, '0, '0, '0, '0);
            2'd1:    issue(1'b1, code, rd_ena, data, rd_addr, sel, addr);
            2'd2:    issue(1'b1, inst_load, rd_ena, data, rd_addr, sel, addr);
            default: issue(1'b1, inst_store, rd_ena, data, rd_addr, sel, addr);
        endcase
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles with %0d results still expected", cycles, pending);
            $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors + 1);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        arst_n       <= 1'b0;
        ex_valid     <= 1'b0;
        ex_inst_type <= '0;
        ex_rd_ena    <= 1'b0;
        ex_rd_data   <= '0;
        ex_rd_addr   <= '0;
        ex_ls_sel    <= '0;
        ex_ls_addr   <= '0;
        exp_word     <= '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        if (!ex_ready || wb_valid) begin
            $display("ex_ready low or wb_valid high right after reset");
            tb_errors++;
        end

        // alu result two edges after it is taken
        issue(1'b1, inst_alu, 1'b1, 32'hcafe_0123, 5'd7, 3'd0, 32'd0);
        ex_valid <= 1'b0;
        @(posedge clk);
        if (wb_valid) begin
            $display("alu result came out one edge after it was taken");
            tb_errors++;
        end
        @(posedge clk);
        if (!wb_valid) begin
            $display("alu result missing two edges after it was taken");
            tb_errors++;
        end

        for (int w = 0; w < 16; w++)
            issue(1'b1, inst_store, 1'b0, take_bits(32), 5'(w), {1'b0, size_word}, 32'(w * 4));

        // word store then load of the same word through other upper bits
        issue(1'b1, inst_store, 1'b1, 32'h8bad_f00d, 5'd3, {1'b0, size_word}, 32'h0000_0420);
        issue(1'b1, inst_load, 1'b1, 32'd0, 5'd9, {1'b0, size_word}, 32'h0000_0020);

        issue(1'b1, inst_store, 1'b1, 32'h1234_5685, 5'd1, {1'b0, size_byte}, 32'h0000_0025);
        issue(1'b1, inst_store, 1'b1, 32'h5678_9abc, 5'd2, {1'b0, size_half}, 32'h0000_0026);
        for (int b = 0; b < 4; b++) begin
            for (int u = 0; u < 2; u++)
                issue(1'b1, inst_load, 1'b1, 32'd0, 5'(b + 10), {1'(u), size_byte}, 32'h24 + 32'(b));
        end
        for (int h = 0; h < 2; h++) begin
            for (int u = 0; u < 2; u++)
                issue(1'b1, inst_load, 1'b1, 32'd0, 5'(h + 20), {1'(u), size_half}, 32'h24 + 32'(2 * h));
        end
        issue(1'b1, inst_load, 1'b1, 32'd0, 5'd31, {1'b0, size_word}, 32'h0000_0024);

        repeat (n_random) issue_random();
        ex_valid <= 1'b0;
        @(posedge clk);
        while (pending != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);        // idle cycles, no writeback may show up

        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/data_ram.sv
////////////////////
// contents come up undefined, write before read
////////////////////
`default_nettype none

module data_ram import mem_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    dmem_if.slave  dmem
);

    logic [xlen-1:0]    mem [dmem_words];
    logic [dmem_aw-1:0] widx;
    logic               start;
    logic               ack_q;
    logic [xlen-1:0]    rdata_q;

    assign widx  = dmem.addr[dmem_aw+1:2];   // word index, upper bits ignored
    assign start = dmem.req && !ack_q;       // new request seen

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else if (start) begin
            ack_q <= 1'b1;
        end else if (!dmem.req && ack_q) begin
            ack_q <= 1'b0;                   // req gone, finish the handshake
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (dmem.we) begin
                for (int i = 0; i < strb_w; i++) begin
                    if (dmem.wstrb[i])
                        mem[widx][8*i +: 8] <= dmem.wdata[8*i +: 8];
                end
            end else begin
                rdata_q <= mem[widx];
            end
        end
    end

    assign dmem.ack   = ack_q;
    assign dmem.rdata = rdata_q;

endmodule

`default_nettype wire

//--- verilog/dmem_if.sv
////////////////////
// four-phase req/ack data memory port
// rdata only valid while ack is high
////////////////////
`default_nettype none

interface dmem_if import mem_pkg::*; ();

    logic              req;
    logic              we;
    logic [xlen-1:0]   addr;
    logic [xlen-1:0]   wdata;
    logic [strb_w-1:0] wstrb;
    logic              ack;
    logic [xlen-1:0]   rdata;

    modport master (
        output req, we, addr, wdata, wstrb,
        input  ack, rdata
    );

    modport slave (
        input  req, we, addr, wdata, wstrb,
        output ack, rdata
    );

endinterface

`default_nettype wire

//--- verilog/ex_mem.sv
////////////////////
// ex/mem register, upstream holds its inputs while ex_ready is low
////////////////////
`default_nettype none

module ex_mem import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ex_valid,
    input  logic [inst_type_w-1:0] ex_inst_type,
    input  logic                   ex_rd_ena,
    input  logic [xlen-1:0]        ex_rd_data,
    input  logic [reg_addr_w-1:0]  ex_rd_addr,
    input  ls_sel_u                ex_ls_sel,
    input  logic [xlen-1:0]        ex_ls_addr,
    output logic                   ex_ready,
    mem_stage_if.reg_side          stage
);

    // free, or the held instruction leaves at this edge
    assign ex_ready = !stage.valid || stage.done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage.valid      <= 1'b0;
            stage.inst_type  <= '0;
            stage.rd_ena     <= 1'b0;
            stage.rd_data    <= '0;
            stage.rd_addr    <= '0;
            stage.ls_sel.raw <= '0;
            stage.ls_addr    <= '0;
        end else if (ex_ready) begin
            if (ex_valid) begin
                stage.valid     <= 1'b1;
                stage.inst_type <= ex_inst_type;
                stage.rd_ena    <= ex_rd_ena;
                stage.rd_data   <= ex_rd_data;
                stage.rd_addr   <= ex_rd_addr;
                stage.ls_sel    <= ex_ls_sel;
                stage.ls_addr   <= ex_ls_addr;
            end else begin
                // nothing offered, insert a bubble
                stage.valid      <= 1'b0;
                stage.inst_type  <= '0;
                stage.rd_ena     <= 1'b0;
                stage.rd_data    <= '0;
                stage.rd_addr    <= '0;
                stage.ls_sel.raw <= '0;
                stage.ls_addr    <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_access.sv
////////////////////
// load/store stage, one access in flight at a time
// misaligned addresses are not handled
////////////////////
`default_nettype none

module mem_access import mem_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    mem_stage_if.stage_side       stage,
    dmem_if.master                dmem,
    output logic                  wb_valid,
    output logic                  wb_rd_ena,
    output logic [reg_addr_w-1:0] wb_rd_addr,
    output logic [xlen-1:0]       wb_rd_data
);

    logic              is_load;
    logic              is_store;
    logic              is_mem;
    logic [1:0]        state_q;
    logic              req_q;
    logic [4:0]        lane_shift;
    logic [xlen-1:0]   rdata_sh;
    logic [xlen-1:0]   load_val;
    logic [xlen-1:0]   wb_data_nxt;
    logic [strb_w-1:0] strb;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (stage.inst_type)
            inst_load:  is_load  = 1'b1;
            inst_store: is_store = 1'b1;
            inst_alu:   ;
            default:    ;                     // treated as alu
        endcase
    end

    assign is_mem     = is_load || is_store;
    assign lane_shift = {stage.ls_addr[1:0], 3'b000};

    // alu finishes at once, memory ops when ack comes back
    assign stage.done = stage.valid && (!is_mem || (state_q == st_request && dmem.ack));

    // handshake sequencer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            req_q   <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (stage.valid && is_mem && !dmem.ack) begin
                        req_q   <= 1'b1;
                        state_q <= st_request;
                    end
                end
                st_request: begin
                    if (dmem.ack) begin
                        req_q   <= 1'b0;
                        state_q <= st_release;
                    end
                end
                st_release: begin
                    // wait for ack low before the next request
                    if (!dmem.ack) begin
                        if (stage.valid && is_mem) begin
                            req_q   <= 1'b1;
                            state_q <= st_request;
                        end else begin
                            state_q <= st_idle;
                        end
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_comb begin
        case (stage.ls_sel.fields.size)
            size_byte: strb = strb_w'(4'b0001) << stage.ls_addr[1:0];
            size_half: strb = strb_w'(4'b0011) << stage.ls_addr[1:0];
            default:   strb = '1;                 // word
        endcase
    end

    assign dmem.req   = req_q;
    assign dmem.we    = is_store;
    assign dmem.addr  = stage.ls_addr;
    assign dmem.wdata = stage.rd_data << lane_shift;  // move into byte lane
    assign dmem.wstrb = strb;

    // load lane select and extension
    assign rdata_sh = dmem.rdata >> lane_shift;

    always_comb begin
        case (stage.ls_sel.fields.size)
            size_byte: begin
                if (stage.ls_sel.fields.unsigned_flag)
                    load_val = {{(xlen-8){1'b0}}, rdata_sh[7:0]};
                else
                    load_val = {{(xlen-8){rdata_sh[7]}}, rdata_sh[7:0]};
            end
            size_half: begin
                if (stage.ls_sel.fields.unsigned_flag)
                    load_val = {{(xlen-16){1'b0}}, rdata_sh[15:0]};
                else
                    load_val = {{(xlen-16){rdata_sh[15]}}, rdata_sh[15:0]};
            end
            default:   load_val = dmem.rdata;     // word
        endcase
    end

    assign wb_data_nxt = is_load ? load_val : stage.rd_data;

    // writeback register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid  <= 1'b0;
            wb_rd_ena <= 1'b0;
        end else begin
            wb_valid <= stage.done;
            if (stage.done)
                wb_rd_ena <= stage.rd_ena && !is_store;  // stores write no register
        end
    end

    always_ff @(posedge clk) begin
        if (stage.done) begin
            wb_rd_addr <= stage.rd_addr;
            wb_rd_data <= wb_data_nxt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_pipe_top.sv
////////////////////
// ex/mem register, load/store stage and data ram
// hold ex_* stable while ex_ready is low
////////////////////
`default_nettype none

module mem_pipe_top import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ex_valid,
    input  logic [inst_type_w-1:0] ex_inst_type,
    input  logic                   ex_rd_ena,      // ignored for stores
    input  logic [xlen-1:0]        ex_rd_data,     // store data for stores
    input  logic [reg_addr_w-1:0]  ex_rd_addr,
    input  logic [2:0]             ex_ls_sel,
    input  logic [xlen-1:0]        ex_ls_addr,
    output logic                   ex_ready,
    output logic                   wb_valid,
    output logic                   wb_rd_ena,
    output logic [reg_addr_w-1:0]  wb_rd_addr,
    output logic [xlen-1:0]        wb_rd_data
);

    mem_stage_if stage_bus ();
    dmem_if      dmem_bus ();

    ex_mem ex_mem_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex_valid     (ex_valid),
        .ex_inst_type (ex_inst_type),
        .ex_rd_ena    (ex_rd_ena),
        .ex_rd_data   (ex_rd_data),
        .ex_rd_addr   (ex_rd_addr),
        .ex_ls_sel    (ex_ls_sel),
        .ex_ls_addr   (ex_ls_addr),
        .ex_ready     (ex_ready),
        .stage        (stage_bus.reg_side)
    );

    mem_access mem_access_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .stage      (stage_bus.stage_side),
        .dmem       (dmem_bus.master),
        .wb_valid   (wb_valid),
        .wb_rd_ena  (wb_rd_ena),
        .wb_rd_addr (wb_rd_addr),
        .wb_rd_data (wb_rd_data)
    );

    data_ram data_ram_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .dmem   (dmem_bus.slave)
    );

endmodule

`default_nettype wire

//--- verilog/mem_pkg.sv
////////////////////
// shared widths and codes for the memory slice
// addresses are assumed naturally aligned
////////////////////
`default_nettype none

package mem_pkg;

    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int inst_type_w = 8;
    localparam int strb_w      = xlen / 8;

    // ram uses word address bits 9:2, upper bits ignored
    localparam int dmem_words  = 256;
    localparam int dmem_aw     = $clog2(dmem_words);

    localparam logic [inst_type_w-1:0] inst_alu   = 8'h01; // unknown codes behave like alu
    localparam logic [inst_type_w-1:0] inst_load  = 8'h02;
    localparam logic [inst_type_w-1:0] inst_store = 8'h04;

    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    // load/store sequencer states
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_request = 2'd1;
    localparam logic [1:0] st_release = 2'd2;

    typedef struct packed {
        logic       unsigned_flag; // funct3[2]
        logic [1:0] size;          // funct3[1:0]
    } ls_fields_t;

    // funct3 of a load/store, seen as raw bits or as its fields
    typedef union packed {
        logic [2:0] raw;
        ls_fields_t fields;
    } ls_sel_u;

endpackage

`default_nettype wire

//--- verilog/mem_stage_if.sv
////////////////////
// registered instruction into the load/store stage
////////////////////
`default_nettype none

interface mem_stage_if import mem_pkg::*; ();

    logic                   valid;
    logic [inst_type_w-1:0] inst_type;
    logic                   rd_ena;
    logic [xlen-1:0]        rd_data;   // alu result or store data
    logic [reg_addr_w-1:0]  rd_addr;
    ls_sel_u                ls_sel;
    logic [xlen-1:0]        ls_addr;
    logic                   done;      // held instruction finishes this cycle

    modport reg_side (
        output valid, inst_type, rd_ena, rd_data, rd_addr, ls_sel, ls_addr,
        input  done
    );

    modport stage_side (
        input  valid, inst_type, rd_ena, rd_data, rd_addr, ls_sel, ls_addr,
        output done
    );

endinterface

`default_nettype wire
